//--- hw/cpu_macros.svh
// width, reset pc and multiplier step constants for the pipeline
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath
`define XLEN               32
`define REG_ADDR_W         5
`define IMM_W              16

// program counter
`define RESET_PC           32'hbfc0_0000
`define PC_STEP            4

// iterative multiplier, radix 16
`define MUL_BITS_PER_STEP  4
`define MUL_STEPS          (`XLEN / `MUL_BITS_PER_STEP)

`endif

//--- hw/cpu_pkg.sv
// opcode and control state enums, instruction and stage register structs
`include "cpu_macros.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LI,     // zero-extended 16-bit immediate
        OP_MUL     // low word of product
    } opcode_e;

    typedef enum logic {
        CTRL_RUN,
        CTRL_MUL_WAIT
    } ctrl_state_e;

    // decoded instruction from the source
    typedef struct packed {
        opcode_e                 opcode;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`IMM_W-1:0]       imm;
    } instr_t;

    typedef struct packed {
        logic                    valid;
        opcode_e                 opcode;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        pc;
        logic [`XLEN-1:0]        a;
        logic [`XLEN-1:0]        b;
    } id_ex_t;

    // execute result, also the forwarding record
    typedef struct packed {
        logic                    valid;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        pc;
        logic [`XLEN-1:0]        result;
    } wb_t;

endpackage

//--- hw/pipe_control.sv
// control FSM producing the decode stall and execute hold around a multiply
`include "cpu_macros.svh"

module pipe_control
    import cpu_pkg::*;
(
    input  logic  aclk,
    input  logic  rst_n,
    input  logic  mul_start,
    input  logic  mul_done,
    output logic  stall,
    output logic  ex_hold
);

    ctrl_state_e state;
    ctrl_state_e state_next;
    logic        hold;

    always_comb begin
        state_next = state;
        case (state)
            CTRL_RUN: begin
                if (mul_start) begin
                    state_next = CTRL_MUL_WAIT;
                end
            end
            CTRL_MUL_WAIT: begin
                if (mul_done) begin
                    state_next = CTRL_RUN;
                end
            end
            default: state_next = CTRL_RUN;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CTRL_RUN;
        end else begin
            state <= state_next;
        end
    end

    // up from the start cycle, down in the done cycle
    // so the product and the next instruction move on the same edge
    assign hold = mul_start || ((state == CTRL_MUL_WAIT) && !mul_done);

    assign stall   = hold;  // freezes pc and id_ex
    assign ex_hold = hold;  // keeps id_ex, bubble into wb

endmodule

//--- hw/mul_unit.sv
// iterative radix-16 shift-add multiplier with step counter
`include "cpu_macros.svh"

module mul_unit (
    input  logic              aclk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [`XLEN-1:0]  a,
    input  logic [`XLEN-1:0]  b,
    output logic              done,
    output logic [`XLEN-1:0]  product
);

    localparam int CNT_W = $clog2(`MUL_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MUL_STEPS - 1);

    logic             busy;
    logic [CNT_W-1:0] step;
    logic [`XLEN-1:0] a_sh;     // multiplier with the low digit consumed first
    logic [`XLEN-1:0] b_sh;     // multiplicand at the current digit weight
    logic [`XLEN-1:0] acc;
    logic [`XLEN-1:0] digit;
    logic [`XLEN-1:0] partial;

    assign digit   = {{(`XLEN - `MUL_BITS_PER_STEP){1'b0}}, a_sh[`MUL_BITS_PER_STEP-1:0]};
    assign partial = b_sh * digit;  // low word only
    assign product = acc + partial;
    assign done    = busy && (step == LAST_STEP);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            step <= '0;
        end else if (busy) begin
            busy <= !done;
            step <= step + CNT_W'(1);   // wraps back to zero after the last step
        end
    end

    // operand and accumulator registers
    always_ff @(posedge aclk) begin
        if (start) begin
            a_sh <= a;
            b_sh <= b;
            acc  <= '0;
        end else if (busy) begin
            a_sh <= a_sh >> `MUL_BITS_PER_STEP;
            b_sh <= b_sh << `MUL_BITS_PER_STEP;
            acc  <= product;
        end
    end

endmodule

//--- hw/decode_stage.sv
// register file, operand forwarding, pc counter and id/ex pipeline register
`include "cpu_macros.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic    aclk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  instr_t  instr,
    input  logic    stall,
    input  wb_t     ex_fwd,
    input  wb_t     wb,
    output id_ex_t  id_ex
);

    localparam int NUM_REGS = 2 ** `REG_ADDR_W;

    logic [`XLEN-1:0] regs [NUM_REGS];
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] op_rs;
    logic [`XLEN-1:0] op_rt;
    logic [`XLEN-1:0] imm_ext;
    logic             accept;
    logic             is_li;
    id_ex_t           id_ex_next;

    // register zero, then execute, then writeback, then the file
    function automatic logic [`XLEN-1:0] fwd_operand(
        input logic [`REG_ADDR_W-1:0] r,
        input wb_t                    ex_res,
        input wb_t                    wb_res,
        input logic [`XLEN-1:0]       rf_val
    );
        logic [`XLEN-1:0] val;
        if (r == '0) begin
            val = '0;
        end else if (ex_res.valid && (ex_res.rd == r)) begin
            val = ex_res.result;
        end else if (wb_res.valid && (wb_res.rd == r)) begin
            val = wb_res.result;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    // register file write port, r0 never written
    always_ff @(posedge aclk) begin
        if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.result;
        end
    end

    assign accept  = instr_valid && !stall;
    assign is_li   = (instr.opcode == OP_LI);
    assign imm_ext = {{(`XLEN - `IMM_W){1'b0}}, instr.imm};
    assign op_rs   = fwd_operand(instr.rs, ex_fwd, wb, regs[instr.rs]);
    assign op_rt   = fwd_operand(instr.rt, ex_fwd, wb, regs[instr.rt]);

    always_comb begin
        id_ex_next.valid  = instr_valid;   // bubble when nothing offered
        id_ex_next.opcode = instr.opcode;
        id_ex_next.rd     = instr.rd;
        id_ex_next.pc     = pc_q;
        id_ex_next.a      = is_li ? '0 : op_rs;
        id_ex_next.b      = is_li ? imm_ext : op_rt;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `RESET_PC;
        end else if (accept) begin
            pc_q <= pc_q + `XLEN'(`PC_STEP);
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= id_ex_next;
        end
    end

endmodule

//--- hw/execute_stage.sv
// ALU, multiplier instance and the ex/wb pipeline register
`include "cpu_macros.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic    aclk,
    input  logic    rst_n,
    input  id_ex_t  id_ex,
    input  logic    ex_hold,
    output wb_t     ex_fwd,
    output wb_t     wb,
    output logic    mul_start,
    output logic    mul_done
);

    logic             is_mul;
    logic             issued;    // multiply already handed to mul_unit
    logic [`XLEN-1:0] product;
    logic [`XLEN-1:0] alu_out;

    assign is_mul    = id_ex.valid && (id_ex.opcode == OP_MUL);
    assign mul_start = is_mul && !issued;

    mul_unit u_mul_unit (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .start    (mul_start),
        .a        (id_ex.a),
        .b        (id_ex.b),
        .done     (mul_done),
        .product  (product)
    );

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            issued <= 1'b0;
        end else if (mul_done) begin
            issued <= 1'b0;
        end else if (mul_start) begin
            issued <= 1'b1;
        end
    end

    always_comb begin
        case (id_ex.opcode)
            OP_ADD:  alu_out = id_ex.a + id_ex.b;
            OP_SUB:  alu_out = id_ex.a - id_ex.b;
            OP_AND:  alu_out = id_ex.a & id_ex.b;
            OP_OR:   alu_out = id_ex.a | id_ex.b;
            OP_XOR:  alu_out = id_ex.a ^ id_ex.b;
            OP_LI:   alu_out = id_ex.b;
            OP_MUL:  alu_out = product;
            default: alu_out = '0;
        endcase
    end

    // a multiply is final only in its done cycle
    always_comb begin
        ex_fwd.valid  = id_ex.valid && (!is_mul || mul_done);
        ex_fwd.rd     = (id_ex.opcode == OP_NOP) ? '0 : id_ex.rd;  // nop writes nothing
        ex_fwd.pc     = id_ex.pc;
        ex_fwd.result = alu_out;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (ex_hold) begin
            wb.valid <= 1'b0;       // bubble while the multiply runs
        end else begin
            wb <= ex_fwd;
        end
    end

endmodule

//--- hw/cpu_top.sv
// pipeline top with control, decode, execute and the golden trace outputs
`include "cpu_macros.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                    aclk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  instr_t                  instr,
    output logic                    stall,
    output logic [`XLEN-1:0]        debug_wb_pc,
    output logic [`XLEN-1:0]        debug_wb_rf_wdata,
    output logic [3:0]              debug_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0]  debug_wb_rf_wnum
);

    id_ex_t id_ex;
    wb_t    ex_fwd;     // execute result before the register
    wb_t    wb;
    logic   mul_start;
    logic   mul_done;
    logic   ex_hold;

    pipe_control u_pipe_control (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .mul_start  (mul_start),
        .mul_done   (mul_done),
        .stall      (stall),
        .ex_hold    (ex_hold)
    );

    decode_stage u_decode_stage (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .stall        (stall),
        .ex_fwd       (ex_fwd),
        .wb           (wb),
        .id_ex        (id_ex)
    );

    execute_stage u_execute_stage (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .ex_hold    (ex_hold),
        .ex_fwd     (ex_fwd),
        .wb         (wb),
        .mul_start  (mul_start),
        .mul_done   (mul_done)
    );

    // golden trace from the writeback register
    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wdata = wb.result;
    assign debug_wb_rf_wnum  = wb.rd;
    assign debug_wb_rf_wen   = (wb.valid && (wb.rd != '0)) ? 4'b1111 : 4'b0000;

endmodule

//--- verification/cpu_tb.sv
// testbench for cpu_top with directed and random programs checked against a reference model
`include "cpu_macros.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int CLK_HALF      = 4;
    localparam int N_RANDOM      = 300;
    localparam int N_DIRECTED    = 40;     // upper bound over the directed tests
    localparam int CYC_PER_INSTR = `MUL_STEPS + 2;
    localparam int WATCHDOG_CYC  = (N_RANDOM + N_DIRECTED) * CYC_PER_INSTR + 100;

    // one expected writeback
    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic [31:0]            due;   // edge count when it shows on the trace
    } exp_t;

    logic                   aclk;
    logic                   rst_n;
    logic                   instr_valid;
    instr_t                 instr;
    logic                   stall;
    logic [`XLEN-1:0]       debug_wb_pc;
    logic [`XLEN-1:0]       debug_wb_rf_wdata;
    logic [3:0]             debug_wb_rf_wen;
    logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum;

    exp_t             exp_q[$];
    logic [`XLEN-1:0] model_rf [2**`REG_ADDR_W];
    logic [`XLEN-1:0] exp_pc;
    logic [31:0]      rng;
    logic [31:0]      cyc = '0;
    int               err_cnt;
    int               check_cnt;

    cpu_top UUT (
        .aclk               (aclk),
        .rst_n              (rst_n),
        .instr_valid        (instr_valid),
        .instr              (instr),
        .stall              (stall),
        .debug_wb_pc        (debug_wb_pc),
        .debug_wb_rf_wdata  (debug_wb_rf_wdata),
        .debug_wb_rf_wen    (debug_wb_rf_wen),
        .debug_wb_rf_wnum   (debug_wb_rf_wnum)
    );

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF aclk = ~aclk;
    end

    always @(posedge aclk) cyc <= cyc + 32'd1;  // rising edges so far

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [`XLEN-1:0] ref_result(
        input instr_t           ins,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        logic [2*`XLEN-1:0] full;
        logic [`XLEN-1:0]   r;
        full = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        case (ins.opcode)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_LI:   r = {{(`XLEN - `IMM_W){1'b0}}, ins.imm};
            OP_MUL:  r = full[`XLEN-1:0];   // low word only
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic instr_t make_instr(
        input opcode_e                op,
        input logic [`REG_ADDR_W-1:0] rd,
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`REG_ADDR_W-1:0] rt,
        input logic [`IMM_W-1:0]      imm
    );
        instr_t ins;
        ins.opcode = op;
        ins.rd     = rd;
        ins.rs     = rs;
        ins.rt     = rt;
        ins.imm    = imm;
        return ins;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // offer one instruction and hold it while stall is up
    task automatic issue(input instr_t ins, output int waited);
        exp_t e;
        @(negedge aclk);
        instr_valid = 1'b1;
        instr       = ins;
        waited      = 0;
        while (stall) begin
            waited++;
            @(negedge aclk);
        end
        e.pc   = exp_pc;
        e.rd   = ins.rd;
        e.data = ref_result(ins, model_rf[ins.rs], model_rf[ins.rt]);
        e.due  = cyc + ((ins.opcode == OP_MUL) ? 32'(`MUL_STEPS) + 32'd2 : 32'd2);
        exp_q.push_back(e);
        if (ins.rd != '0) begin
            model_rf[ins.rd] = e.data;   // r0 stays zero
        end
        exp_pc = exp_pc + 32'(`PC_STEP);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge aclk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) @(negedge aclk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %0d errors at %0t", name, err_cnt - errs_before, $time);
    endtask

    task automatic check_entry(input exp_t e);
        check(debug_wb_pc, e.pc, "writeback pc");
        check(32'(debug_wb_rf_wnum), 32'(e.rd), "writeback register");
        check(debug_wb_rf_wdata, e.data, "writeback data");
        check(32'(debug_wb_rf_wen), (e.rd == '0) ? 32'd0 : 32'hf, "write enable");
        check(cyc, e.due, "writeback edge");
    endtask

    // trace compare, outputs are stable at the falling edge
    always @(negedge aclk) begin
        exp_t e;
        if (rst_n && (debug_wb_rf_wen != 4'b0000)) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("unexpected register write to r%0d at %0t", debug_wb_rf_wnum, $time);
            end else begin
                e = exp_q.pop_front();
                check_entry(e);
            end
        end else if (rst_n && (exp_q.size() != 0)) begin
            if ((exp_q[0].rd == '0) && (exp_q[0].pc == debug_wb_pc) && (exp_q[0].due == cyc)) begin
                e = exp_q.pop_front();   // r0 write, seen by its pc
                check_entry(e);
            end else if (cyc > exp_q[0].due) begin
                e = exp_q.pop_front();
                err_cnt++;
                $display("writeback of pc %h to r%0d never appeared", e.pc, e.rd);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYC * 2 * CLK_HALF);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("sim failed");
        $finish;
    end

    initial begin
        int         waited;
        int         errs_before;
        int         gap;
        instr_t     ins;
        logic [2:0] op_bits;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rng         = 32'ha196_f762;
        exp_pc      = `RESET_PC;
        err_cnt     = 0;
        check_cnt   = 0;
        model_rf    = '{default: '0};
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;

        errs_before = err_cnt;
        repeat (6) begin
            @(negedge aclk);
            check(32'(stall), 32'd0, "stall after reset");
            check(32'(debug_wb_rf_wen), 32'd0, "write enable after reset");
        end
        report_test("reset state", errs_before);

        errs_before = err_cnt;
        for (int i = 1; i < 8; i++) begin
            issue(make_instr(OP_LI, 5'(i), 5'd0, 5'd0, 16'(16'h1111 * i)), waited);
        end
        issue(make_instr(OP_LI,  5'd1, 5'd0, 5'd0, 16'hf00d), waited);
        issue(make_instr(OP_ADD, 5'd2, 5'd1, 5'd1, 16'h0), waited);   // ex_fwd on both
        issue(make_instr(OP_SUB, 5'd3, 5'd2, 5'd1, 16'h0), waited);   // ex_fwd and wb
        issue(make_instr(OP_AND, 5'd4, 5'd3, 5'd2, 16'h0), waited);
        issue(make_instr(OP_OR,  5'd5, 5'd4, 5'd3, 16'h0), waited);
        issue(make_instr(OP_XOR, 5'd6, 5'd5, 5'd4, 16'h0), waited);
        drain();
        report_test("alu forwarding chain", errs_before);

        errs_before = err_cnt;
        issue(make_instr(OP_LI,  5'd1, 5'd0, 5'd0, 16'hbeef), waited);
        issue(make_instr(OP_LI,  5'd2, 5'd0, 5'd0, 16'h1234), waited);
        issue(make_instr(OP_MUL, 5'd3, 5'd1, 5'd2, 16'h0), waited);
        issue(make_instr(OP_ADD, 5'd4, 5'd3, 5'd1, 16'h0), waited);   // uses the product
        check(32'(waited), 32'(`MUL_STEPS), "stall cycles behind mul");
        issue(make_instr(OP_MUL, 5'd5, 5'd3, 5'd4, 16'h0), waited);   // wraps past 32 bits
        issue(make_instr(OP_XOR, 5'd6, 5'd5, 5'd3, 16'h0), waited);
        check(32'(waited), 32'(`MUL_STEPS), "stall cycles behind mul");
        drain();
        report_test("multiply stall", errs_before);

        errs_before = err_cnt;
        issue(make_instr(OP_LI,  5'd0, 5'd0, 5'd0, 16'hbeef), waited);
        issue(make_instr(OP_ADD, 5'd0, 5'd1, 5'd2, 16'h0), waited);
        issue(make_instr(OP_ADD, 5'd7, 5'd0, 5'd0, 16'h0), waited);   // r0 in ex_fwd
        issue(make_instr(OP_OR,  5'd6, 5'd0, 5'd1, 16'h0), waited);
        drain();
        report_test("register zero", errs_before);

        errs_before = err_cnt;
        for (int n = 0; n < N_RANDOM; n++) begin
            rng        = xorshift(rng);
            op_bits    = 3'(32'd1 + (rng % 32'd7));   // no nop
            ins.opcode = opcode_e'(op_bits);
            ins.rd     = {2'b00, rng[10:8]};          // few registers, many hazards
            ins.rs     = {2'b00, rng[13:11]};
            ins.rt     = {2'b00, rng[16:14]};
            ins.imm    = rng[31:16];
            issue(ins, waited);
            rng = xorshift(rng);
            gap = (rng[1:0] == 2'b00) ? int'(rng[3:2]) + 1 : 0;
            idle(gap);
        end
        drain();
        report_test("random program", errs_before);

        $display("tests: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/cpu_pkg.sv
hw/pipe_control.sv
hw/mul_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu_top.sv
verification/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the pipeline testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f project.f --top-module cpu_tb -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/cpu_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$log"; then
    exit 0
fi

echo "pass line not found in $log"
exit 1
